// ==== common/core_pkg.sv ====
package core_pkg;

	// ========================================
	// Core constants
	// ========================================
	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int NREGS       = 32;
	localparam int INSTR_BYTES = 4;

	// First fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC  = '0;
	// ADDI x0, x0, 0
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

	// Major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_ALUI   = 7'b0010011;
	localparam logic [6:0] OP_ALUR   = 7'b0110011;

	// funct3 of the ALU group
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR  = 3'b101;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct3 of the branch group
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;

	// ========================================
	// Enumerations
	// ========================================
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLL, ALU_SRL, ALU_EQ, ALU_NE, ALU_LT, ALU_GE
	} alu_op_t;

	typedef enum logic [2:0] {
		S_IFETCH, S_IDECODE, S_EXEC, S_MEM, S_WB
	} state_t;

	typedef enum logic [2:0] {
		CL_ALU, CL_LUI, CL_JAL, CL_BRANCH, CL_LOAD, CL_STORE
	} instr_class_t;

endpackage

// ==== core_control/core_idecode.sv ====
module core_idecode import core_pkg::*; (
	input  logic                  CLK,
	input  logic                  NRST,
	input  logic [XLEN-1:0]       instruction,
	input  logic                  c_decode,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	output logic [REG_ADDR_W-1:0] rd,
	output logic [XLEN-1:0]       imm,
	output alu_op_t               alu_op,
	output logic                  is_imm,
	output instr_class_t          instr_class
);

	logic [XLEN-1:0] instr_q;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            funct7_b5;
	logic            opcode_ok;

	// Instruction register, one cycle behind c_decode
	always_ff @(posedge CLK)
	begin
		if (!NRST)
			instr_q <= NOP_INSTR;
		else if (c_decode)
			instr_q <= instruction;
	end

	// Fixed field positions
	assign opcode    = instr_q[6:0];
	assign funct3    = instr_q[14:12];
	assign funct7_b5 = instr_q[30];
	assign rs1       = instr_q[19:15];
	assign rs2       = instr_q[24:20];
	assign rd        = instr_q[11:7];

	// ========================================
	// Class and immediate format
	// ========================================
	always_comb
	begin
		instr_class = CL_ALU;
		is_imm      = 1'b0;
		opcode_ok   = 1'b1;
		// I-type by default
		imm         = {{20{instr_q[31]}}, instr_q[31:20]};
		case (opcode)
			OP_ALUR:
				instr_class = CL_ALU;
			OP_ALUI:
				is_imm = 1'b1;
			OP_LOAD:
			begin
				instr_class = CL_LOAD;
				is_imm      = 1'b1;
			end
			OP_STORE:
			begin
				instr_class = CL_STORE;
				is_imm      = 1'b1;
				imm         = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
			end
			OP_BRANCH:
			begin
				instr_class = CL_BRANCH;
				imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
					instr_q[30:25], instr_q[11:8], 1'b0};
			end
			OP_LUI:
			begin
				instr_class = CL_LUI;
				imm         = {instr_q[31:12], 12'b0};
			end
			OP_JAL:
			begin
				instr_class = CL_JAL;
				imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
					instr_q[20], instr_q[30:21], 1'b0};
			end
			default:
				opcode_ok = 1'b0;
		endcase
	end

	// ALU operation from funct3 and funct7
	always_comb
	begin
		alu_op = ALU_ADD;
		if (opcode == OP_BRANCH)
		begin
			case (funct3)
				F3_BNE:  alu_op = ALU_NE;
				F3_BLT:  alu_op = ALU_LT;
				F3_BGE:  alu_op = ALU_GE;
				default: alu_op = ALU_EQ;
			endcase
		end
		else if ((opcode == OP_ALUR) || (opcode == OP_ALUI))
		begin
			case (funct3)
				// SUB only in register form
				F3_ADD:  alu_op = ((opcode == OP_ALUR) && funct7_b5) ? ALU_SUB : ALU_ADD;
				F3_SLL:  alu_op = ALU_SLL;
				F3_SLT:  alu_op = ALU_SLT;
				F3_XOR:  alu_op = ALU_XOR;
				F3_SR:   alu_op = ALU_SRL;
				F3_OR:   alu_op = ALU_OR;
				F3_AND:  alu_op = ALU_AND;
				default: alu_op = ALU_ADD;
			endcase
		end
	end

	a_opcode_known: assert property (@(posedge CLK) disable iff (!NRST)
		c_decode |=> opcode_ok);

endmodule

// ==== core_control/core_cmem.sv ====
module core_cmem import core_pkg::*; (
	input  logic            CLK,
	input  logic            NRST,
	input  logic            c_mem,
	input  logic            is_store,
	input  logic [XLEN-1:0] base,
	input  logic [XLEN-1:0] offset,
	input  logic [XLEN-1:0] store_data,
	input  logic            dmem_ack,
	input  logic [XLEN-1:0] dmem_rdata,
	output logic [XLEN-1:0] dmem_addr,
	output logic [XLEN-1:0] dmem_wdata,
	output logic            dmem_rd,
	output logic            dmem_wr,
	output logic            mem_done,
	output logic [XLEN-1:0] load_data
);

	// Address and store word, stable for the whole request
	always_ff @(posedge CLK)
	begin
		if (c_mem)
		begin
			dmem_addr  <= base + offset;
			dmem_wdata <= store_data;
		end
		if (dmem_ack && dmem_rd)
			load_data <= dmem_rdata;
	end

	// Request levels drop the cycle after the acknowledge
	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			dmem_rd <= 1'b0;
			dmem_wr <= 1'b0;
		end
		else if (c_mem)
		begin
			dmem_rd <= !is_store;
			dmem_wr <= is_store;
		end
		else if (dmem_ack)
		begin
			dmem_rd <= 1'b0;
			dmem_wr <= 1'b0;
		end
	end

	// Done in the acknowledge cycle itself
	assign mem_done = dmem_ack && (dmem_rd || dmem_wr);

	a_rd_wr_exclusive: assert property (@(posedge CLK) disable iff (!NRST)
		!(dmem_rd && dmem_wr));

	a_req_stable: assert property (@(posedge CLK) disable iff (!NRST)
		(dmem_rd || dmem_wr) && !dmem_ack |=>
			(dmem_rd || dmem_wr) && $stable(dmem_addr) && $stable(dmem_wdata));

endmodule

// ==== core_control/core_control.sv ====
module core_control import core_pkg::*; (
	input  logic                  CLK,
	input  logic                  NRST,
	// Instruction memory port
	input  logic [XLEN-1:0]       imem_rdata,
	input  logic                  imem_rvalid,
	output logic [XLEN-1:0]       imem_araddr,
	output logic                  imem_arvalid,
	// Register file port
	output logic [REG_ADDR_W-1:0] reg_raddr1,
	output logic [REG_ADDR_W-1:0] reg_raddr2,
	output logic [REG_ADDR_W-1:0] reg_waddr,
	output logic                  reg_we,
	output logic [XLEN-1:0]       reg_wdata,
	input  logic [XLEN-1:0]       reg_rdata1,
	input  logic [XLEN-1:0]       reg_rdata2,
	// ALU port
	output logic [XLEN-1:0]       alu_a,
	output logic [XLEN-1:0]       alu_b,
	output alu_op_t               alu_op,
	input  logic [XLEN-1:0]       alu_result,
	input  logic                  alu_flag,
	// Data memory port
	output logic [XLEN-1:0]       dmem_addr,
	output logic [XLEN-1:0]       dmem_wdata,
	output logic                  dmem_rd,
	output logic                  dmem_wr,
	input  logic                  dmem_ack,
	input  logic [XLEN-1:0]       dmem_rdata
);

	state_t          state;
	state_t          state_next;
	instr_class_t    instr_class;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_target;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] alu_q;
	logic [XLEN-1:0] load_data;
	logic            taken_q;
	logic            is_imm;
	logic            is_mem;
	logic            c_decode;
	logic            c_mem;
	logic            mem_done;

	// Latch the fetched word on the read pulse
	assign c_decode = (state == S_IFETCH) && imem_arvalid && imem_rvalid;
	assign is_mem   = (instr_class == CL_LOAD) || (instr_class == CL_STORE);
	// Memory access starts straight from decode
	assign c_mem    = (state == S_IDECODE) && is_mem;

	core_idecode u_idecode (
		.CLK         (CLK),
		.NRST        (NRST),
		.instruction (imem_rdata),
		.c_decode    (c_decode),
		.rs1         (reg_raddr1),
		.rs2         (reg_raddr2),
		.rd          (reg_waddr),
		.imm         (imm),
		.alu_op      (alu_op),
		.is_imm      (is_imm),
		.instr_class (instr_class)
	);

	core_cmem u_cmem (
		.CLK        (CLK),
		.NRST       (NRST),
		.c_mem      (c_mem),
		.is_store   (instr_class == CL_STORE),
		.base       (reg_rdata1),
		.offset     (imm),
		.store_data (reg_rdata2),
		.dmem_ack   (dmem_ack),
		.dmem_rdata (dmem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rd    (dmem_rd),
		.dmem_wr    (dmem_wr),
		.mem_done   (mem_done),
		.load_data  (load_data)
	);

	// ========================================
	// Datapath selects
	// ========================================
	assign pc_plus4    = pc + INSTR_BYTES;
	assign pc_target   = pc + imm;
	assign imem_araddr = pc;
	assign alu_a       = reg_rdata1;
	// Immediate forms replace rs2
	assign alu_b       = is_imm ? imm : reg_rdata2;

	// Branches write nothing back
	assign reg_we = (state == S_WB) && (instr_class != CL_BRANCH);

	always_comb
	begin
		case (instr_class)
			CL_LUI:  reg_wdata = imm;
			// Link address
			CL_JAL:  reg_wdata = pc_plus4;
			CL_LOAD: reg_wdata = load_data;
			default: reg_wdata = alu_q;
		endcase
	end

	// ========================================
	// Central state machine
	// ========================================
	always_comb
	begin
		state_next = state;
		case (state)
			S_IFETCH:
				if (c_decode)
					state_next = S_IDECODE;
			S_IDECODE:
				state_next = is_mem ? S_MEM : S_EXEC;
			S_EXEC:
				state_next = S_WB;
			// Store returns to fetch, load still writes back
			S_MEM:
				if (mem_done)
					state_next = (instr_class == CL_LOAD) ? S_WB : S_IFETCH;
			S_WB:
				state_next = S_IFETCH;
			default:
				state_next = S_IFETCH;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			state        <= S_IFETCH;
			pc           <= RESET_PC;
			taken_q      <= 1'b0;
			imem_arvalid <= 1'b0;
		end
		else
		begin
			state        <= state_next;
			// Request held for the whole fetch state
			imem_arvalid <= (state_next == S_IFETCH);
			if (state == S_IDECODE)
				taken_q <= 1'b0;
			if (state == S_EXEC)
				taken_q <= (instr_class == CL_JAL) ||
					((instr_class == CL_BRANCH) && alu_flag);
			// PC moves on leaving write-back or a finished store
			if (state == S_WB)
				pc <= taken_q ? pc_target : pc_plus4;
			else if ((state == S_MEM) && mem_done && (instr_class == CL_STORE))
				pc <= pc_plus4;
		end
	end

	// Result held for write-back
	always_ff @(posedge CLK)
	begin
		if (state == S_EXEC)
			alu_q <= alu_result;
	end

	a_arvalid_in_fetch: assert property (@(posedge CLK) disable iff (!NRST)
		imem_arvalid |-> (state == S_IFETCH));

	// Write-back only after execute or a finished load
	a_we_in_wb: assert property (@(posedge CLK) disable iff (!NRST)
		reg_we |-> (instr_class != CL_STORE) &&
			$past((state == S_EXEC) || ((state == S_MEM) && mem_done)));

endmodule

// ==== source/core_alu.sv ====
module core_alu import core_pkg::*; (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_t         alu_op,
	output logic [XLEN-1:0] result,
	output logic            flag
);

	logic [4:0] shamt;
	logic       lt_signed;

	// Only the low five bits shift
	assign shamt     = b[4:0];
	assign lt_signed = $signed(a) < $signed(b);

	// ========================================
	// Branch compare
	// ========================================
	always_comb
	begin
		case (alu_op)
			ALU_EQ:  flag = (a == b);
			ALU_NE:  flag = (a != b);
			// Signed for BLT and BGE
			ALU_LT:  flag = lt_signed;
			ALU_GE:  flag = !lt_signed;
			default: flag = 1'b0;
		endcase
	end

	// ========================================
	// Arithmetic, logic and shifts
	// ========================================
	always_comb
	begin
		case (alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLL: result = a << shamt;
			// Logical shift, zero fill
			ALU_SRL: result = a >> shamt;
			// Compare ops return the flag too
			default: result = {{(XLEN-1){1'b0}}, flag};
		endcase
	end

endmodule

// ==== source/core_regfile.sv ====
module core_regfile import core_pkg::*; (
	input  logic                  CLK,
	input  logic                  NRST,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] raddr2,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic                  we,
	input  logic [XLEN-1:0]       wdata,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2
);

	logic [XLEN-1:0] regs [NREGS];

	// Whole file cleared in reset, x0 never written
	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (we && (waddr != '0))
			regs[waddr] <= wdata;
	end

	// Asynchronous reads
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== source/core_top.sv ====
module core_top import core_pkg::*; (
	input  logic            CLK,
	input  logic            NRST,
	// Instruction side
	output logic [XLEN-1:0] imem_araddr,
	output logic            imem_arvalid,
	input  logic            imem_rvalid,
	input  logic [XLEN-1:0] imem_rdata,
	// Data side
	output logic [XLEN-1:0] dmem_addr,
	output logic [XLEN-1:0] dmem_wdata,
	output logic            dmem_rd,
	output logic            dmem_wr,
	input  logic            dmem_ack,
	input  logic [XLEN-1:0] dmem_rdata
);

	// Register file wires
	logic [REG_ADDR_W-1:0] reg_raddr1;
	logic [REG_ADDR_W-1:0] reg_raddr2;
	logic [REG_ADDR_W-1:0] reg_waddr;
	logic                  reg_we;
	logic [XLEN-1:0]       reg_wdata;
	logic [XLEN-1:0]       reg_rdata1;
	logic [XLEN-1:0]       reg_rdata2;
	// ALU wires
	logic [XLEN-1:0]       alu_a;
	logic [XLEN-1:0]       alu_b;
	alu_op_t               alu_op;
	logic [XLEN-1:0]       alu_result;
	logic                  alu_flag;

	core_control u_control (
		.CLK          (CLK),
		.NRST         (NRST),
		.imem_rdata   (imem_rdata),
		.imem_rvalid  (imem_rvalid),
		.imem_araddr  (imem_araddr),
		.imem_arvalid (imem_arvalid),
		.reg_raddr1   (reg_raddr1),
		.reg_raddr2   (reg_raddr2),
		.reg_waddr    (reg_waddr),
		.reg_we       (reg_we),
		.reg_wdata    (reg_wdata),
		.reg_rdata1   (reg_rdata1),
		.reg_rdata2   (reg_rdata2),
		.alu_a        (alu_a),
		.alu_b        (alu_b),
		.alu_op       (alu_op),
		.alu_result   (alu_result),
		.alu_flag     (alu_flag),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_rd      (dmem_rd),
		.dmem_wr      (dmem_wr),
		.dmem_ack     (dmem_ack),
		.dmem_rdata   (dmem_rdata)
	);

	core_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.alu_op (alu_op),
		.result (alu_result),
		.flag   (alu_flag)
	);

	core_regfile u_regfile (
		.CLK    (CLK),
		.NRST   (NRST),
		.raddr1 (reg_raddr1),
		.raddr2 (reg_raddr2),
		.waddr  (reg_waddr),
		.we     (reg_we),
		.wdata  (reg_wdata),
		.rdata1 (reg_rdata1),
		.rdata2 (reg_rdata2)
	);

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock (
	output logic CLK,
	output logic NRST
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 16;

	// 40 ns clock
	initial
	begin
		CLK = 1'b0;
		forever
			#HALF_PERIOD CLK = ~CLK;
	end

	// Reset released 2 ns after the 16th rising edge
	initial
	begin
		NRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2 NRST = 1'b1;
	end

endmodule

// ==== verif/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural state of the software model
logic [31:0] ref_pc;
logic [31:0] ref_regs [32];
logic [31:0] ref_mem [64];
// Expected data access of the last stepped instruction
logic        exp_is_mem;
logic        exp_is_store;
logic [31:0] exp_addr;
logic [31:0] exp_data;

// Executes one instruction on the model state
function automatic void ref_exec(input logic [31:0] ins);
	logic [6:0]  opc;
	logic [2:0]  f3;
	logic [4:0]  rd;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] res;
	logic [31:0] next_pc;
	logic        wr_en;
	logic        taken;
	opc     = ins[6:0];
	f3      = ins[14:12];
	rd      = ins[11:7];
	a       = ref_regs[ins[19:15]];
	b       = ref_regs[ins[24:20]];
	imm_i   = {{20{ins[31]}}, ins[31:20]};
	imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	next_pc = ref_pc + 32'd4;
	wr_en   = 1'b0;
	res     = '0;
	taken   = 1'b0;
	exp_is_mem   = 1'b0;
	exp_is_store = 1'b0;
	case (opc)
		OP_LUI:
		begin
			res   = {ins[31:12], 12'b0};
			wr_en = 1'b1;
		end
		OP_JAL:
		begin
			res     = ref_pc + 32'd4;
			next_pc = ref_pc + imm_j;
			wr_en   = 1'b1;
		end
		OP_BRANCH:
		begin
			case (f3)
				3'b000: taken = (a == b);
				3'b001: taken = (a != b);
				3'b100: taken = ($signed(a) < $signed(b));
				default: taken = ($signed(a) >= $signed(b));
			endcase
			if (taken)
				next_pc = ref_pc + imm_b;
		end
		OP_LOAD:
		begin
			exp_is_mem = 1'b1;
			exp_addr   = a + imm_i;
			res        = ref_mem[exp_addr[7:2]];
			wr_en      = 1'b1;
		end
		OP_STORE:
		begin
			exp_is_mem   = 1'b1;
			exp_is_store = 1'b1;
			exp_addr     = a + imm_s;
			exp_data     = b;
			ref_mem[exp_addr[7:2]] = b;
		end
		default:
		begin
			// Register and immediate ALU forms
			if (opc == OP_ALUI)
				b = imm_i;
			case (f3)
				3'b000: res = (opc == OP_ALUR && ins[30]) ? a - b : a + b;
				3'b001: res = a << b[4:0];
				3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'b100: res = a ^ b;
				3'b101: res = a >> b[4:0];
				3'b110: res = a | b;
				default: res = a & b;
			endcase
			wr_en = 1'b1;
		end
	endcase
	// x0 stays zero
	if (wr_en && rd != 5'd0)
		ref_regs[rd] = res;
	ref_pc = next_pc;
endfunction

`endif

// ==== verif/tb_core.sv ====
module tb_core import core_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LOOP_EXTRA = 4;
	localparam int MAX_WAIT   = 6;

	logic        CLK;
	logic        NRST;
	logic [31:0] imem_araddr;
	logic        imem_arvalid;
	logic        imem_rvalid;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_rd;
	logic        dmem_wr;
	logic        dmem_ack;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	integer      seed = 82148;
	int          n_instr;
	int          cycles;
	int          limit;
	int          rise_due;
	int          halt_seen;
	logic [31:0] halt_pc;
	logic        finished;
	// Memory model state
	logic        fetch_busy;
	int          fetch_wait;
	logic [31:0] fetch_addr;
	logic        data_busy;
	int          data_wait;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;

	`include "tb_ref_model.svh"

	tb_clock u_clock (
		.CLK  (CLK),
		.NRST (NRST)
	);

	core_top DUT (
		.CLK          (CLK),
		.NRST         (NRST),
		.imem_araddr  (imem_araddr),
		.imem_arvalid (imem_arvalid),
		.imem_rvalid  (imem_rvalid),
		.imem_rdata   (imem_rdata),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_rd      (dmem_rd),
		.dmem_wr      (dmem_wr),
		.dmem_ack     (dmem_ack),
		.dmem_rdata   (dmem_rdata)
	);

	// ========================================
	// Checks
	// ========================================
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1, "check failed");
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("error at %0t ns: %s", $time, what);
		$display("Done: errors found");
		$fatal(1, "run failed");
	endtask

	// ========================================
	// Instruction encoders
	// ========================================
	function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2,
		input int rs1, input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_ALUR};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input int imm,
		input int rs1, input logic [2:0] f3, input int rd);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
	endfunction

	// Background word, a function of the whole address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
	endfunction

	task automatic put_instr(input logic [31:0] w);
		imem[n_instr] = w;
		n_instr++;
	endtask

	task automatic load_program();
		n_instr = 0;
		put_instr({20'h12345, 5'd1, OP_LUI});
		put_instr(i_type(OP_ALUI, -7, 0, F3_ADD, 2));
		put_instr(i_type(OP_ALUI, 5, 0, F3_ADD, 3));
		put_instr(r_type(7'h00, 3, 2, F3_ADD, 4));
		put_instr(r_type(7'h20, 2, 3, F3_ADD, 5));
		put_instr(r_type(7'h00, 2, 1, F3_AND, 6));
		put_instr(r_type(7'h00, 3, 2, F3_OR, 7));
		put_instr(r_type(7'h00, 2, 1, F3_XOR, 8));
		put_instr(r_type(7'h00, 3, 2, F3_SLT, 9));
		put_instr(r_type(7'h00, 3, 1, F3_SLL, 10));
		put_instr(r_type(7'h00, 3, 2, F3_SR, 11));
		for (int r = 4; r <= 11; r++)
			put_instr(s_type((r - 4) * 4, r, 0));
		put_instr(i_type(OP_ALUI, 12'h0F0, 2, F3_AND, 12));
		put_instr(i_type(OP_ALUI, -256, 3, F3_OR, 13));
		put_instr(i_type(OP_ALUI, 12'h555, 1, F3_XOR, 14));
		put_instr(i_type(OP_ALUI, -8, 2, F3_SLT, 15));
		put_instr(i_type(OP_ALUI, 4, 2, F3_SLL, 16));
		put_instr(i_type(OP_ALUI, 28, 2, F3_SR, 17));
		for (int r = 12; r <= 17; r++)
			put_instr(s_type(32 + (r - 12) * 4, r, 0));
		// Write to x0, then store x0
		put_instr(i_type(OP_ALUI, 9, 3, F3_ADD, 0));
		put_instr(s_type(56, 0, 0));
		// Count down loop, BNE taken twice
		put_instr(i_type(OP_ALUI, 3, 0, F3_ADD, 18));
		put_instr(i_type(OP_ALUI, -1, 18, F3_ADD, 18));
		put_instr(b_type(-4, 0, 18, F3_BNE));
		put_instr(b_type(8, 3, 3, F3_BEQ));
		put_instr(i_type(OP_ALUI, 1, 0, F3_ADD, 19));
		put_instr(b_type(8, 3, 2, F3_BLT));
		put_instr(i_type(OP_ALUI, 2, 0, F3_ADD, 19));
		put_instr(b_type(8, 3, 2, F3_BGE));
		put_instr(b_type(8, 2, 3, F3_BLT));
		// BGE taken and BEQ not taken
		put_instr(b_type(8, 2, 3, F3_BGE));
		put_instr(i_type(OP_ALUI, 4, 0, F3_ADD, 19));
		put_instr(b_type(8, 3, 2, F3_BEQ));
		put_instr(s_type(60, 19, 0));
		// Loads of a stored and an untouched word
		put_instr(i_type(OP_LOAD, 4, 0, 3'b010, 20));
		put_instr(r_type(7'h00, 20, 20, F3_ADD, 21));
		put_instr(s_type(64, 21, 0));
		put_instr(i_type(OP_LOAD, 100, 0, 3'b010, 22));
		put_instr(s_type(68, 22, 0));
		put_instr(j_type(8, 23));
		put_instr(i_type(OP_ALUI, 7, 0, F3_ADD, 23));
		put_instr(s_type(72, 23, 0));
		// Final self loop
		halt_pc = n_instr * 4;
		put_instr(j_type(0, 0));
	endtask

	// ========================================
	// Memory models
	// ========================================
	task automatic serve_fetch();
		if (rise_due != 0 && cycles == rise_due)
			compare_value("imem_arvalid", imem_arvalid, 1'b1);
		if (imem_rvalid)
		begin
			imem_rvalid = 1'b0;
			fetch_busy  = 1'b0;
		end
		else if (imem_arvalid)
		begin
			if (!fetch_busy)
			begin
				if (exp_is_mem)
					stop_with_error("no data access for the previous load or store");
				compare_value("imem_araddr", imem_araddr, ref_pc);
				// Decode, execute and write-back in between
				if (rise_due != 0)
					compare_value("fetch request cycle", cycles, rise_due);
				rise_due = 0;
				if (imem_araddr == halt_pc)
					halt_seen++;
				if (halt_seen == 2)
					finished = 1'b1;
				fetch_busy = 1'b1;
				fetch_addr = imem_araddr;
				fetch_wait = $unsigned($random(seed)) % MAX_WAIT;
			end
			else
			begin
				compare_value("imem_araddr", imem_araddr, fetch_addr);
				fetch_wait--;
			end
			if (fetch_wait == 0)
			begin
				imem_rvalid = 1'b1;
				imem_rdata  = imem[fetch_addr[7:2]];
				ref_exec(imem_rdata);
				if (!exp_is_mem)
					rise_due = cycles + 4;
			end
		end
		else if (fetch_busy)
			stop_with_error("imem_arvalid dropped before imem_rvalid");
	endtask

	task automatic serve_data();
		if (dmem_ack)
		begin
			dmem_ack  = 1'b0;
			data_busy = 1'b0;
		end
		else if (dmem_rd || dmem_wr)
		begin
			if (!data_busy)
			begin
				compare_value("dmem request", 1'b1, exp_is_mem);
				compare_value("dmem_wr", dmem_wr, exp_is_store);
				compare_value("dmem_rd", dmem_rd, !exp_is_store);
				compare_value("dmem_addr", dmem_addr, exp_addr);
				if (dmem_wr)
					compare_value("dmem_wdata", dmem_wdata, exp_data);
				exp_is_mem = 1'b0;
				data_busy  = 1'b1;
				data_addr  = dmem_addr;
				data_wdata = dmem_wdata;
				data_wait  = $unsigned($random(seed)) % MAX_WAIT;
			end
			else
			begin
				// Request must hold steady until the acknowledge
				compare_value("dmem_addr", dmem_addr, data_addr);
				compare_value("dmem_wdata", dmem_wdata, data_wdata);
				data_wait--;
			end
			if (data_wait == 0)
			begin
				dmem_ack = 1'b1;
				if (dmem_wr)
					dmem[data_addr[7:2]] = data_wdata;
				else
					dmem_rdata = dmem[data_addr[7:2]];
			end
		end
		else if (data_busy)
			stop_with_error("data request dropped before dmem_ack");
	endtask

	// ========================================
	// Stimulus and compare process
	// ========================================
	initial
	begin
		imem_rvalid = 1'b0;
		imem_rdata  = '0;
		dmem_ack    = 1'b0;
		dmem_rdata  = '0;
		for (int i = 0; i < 64; i++)
		begin
			imem[i]     = NOP_INSTR;
			dmem[i]     = fill_word(i * 4);
			ref_mem[i]  = fill_word(i * 4);
		end
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		ref_pc     = RESET_PC;
		exp_is_mem = 1'b0;
		load_program();
		limit      = (n_instr + LOOP_EXTRA) * (4 + 2 * 6) + 16;
		cycles     = 0;
		rise_due   = 0;
		halt_seen  = 0;
		finished   = 1'b0;
		fetch_busy = 1'b0;
		data_busy  = 1'b0;
		while (!finished)
		begin
			@(posedge CLK);
			#1;
			cycles++;
			if (cycles > limit)
				stop_with_error($sformatf("timeout, no final loop after %0d cycles", limit));
			if (!NRST)
			begin
				compare_value("imem_arvalid", imem_arvalid, 1'b0);
				compare_value("dmem_rd", dmem_rd, 1'b0);
				compare_value("dmem_wr", dmem_wr, 1'b0);
			end
			else
			begin
				#1;
				serve_fetch();
				serve_data();
			end
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verif
common/core_pkg.sv
core_control/core_idecode.sv
core_control/core_cmem.sv
core_control/core_control.sv
source/core_alu.sv
source/core_regfile.sv
source/core_top.sv
verif/tb_clock.sv
verif/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_core -f flist.f \
	--Mdir obj_dir -o tb_core > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/tb_core > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
